// File: hdl/track_consts.svh
// steering controller constants
// speed width, proximity speed table, steering offsets
// miss counter width and default limit, apb register offsets
`ifndef TRACK_CONSTS_SVH
`define TRACK_CONSTS_SVH

// signed wheel speed in deg/s
`define TRK_DPS_W 16

// forward speeds, nearest object gets the slowest
`define TRK_VEL0 100
`define TRK_VEL1 150
`define TRK_VEL2 200
`define TRK_VEL3 300
`define TRK_VEL4 400
`define TRK_VEL5 500

// slow-side reduction, grows toward the image edge
`define TRK_OFS1 100
`define TRK_OFS2 150
`define TRK_OFS3 200
`define TRK_OFS4 250

// miss counter, ~50 ms frames x 63 is about 3 s of search
`define TRK_CNT_W     6
`define TRK_LIMIT_RST 63

// apb byte offsets
`define TRK_REG_CTRL  4'h0
`define TRK_REG_LIMIT 4'h4
`define TRK_REG_STAT  4'h8
`define TRK_REG_MOTOR 4'hC

`endif

// File: hdl/track_pkg.sv
// tracker types
// state enum, camera frame report, motor command, run configuration
`include "track_consts.svh"

package track_pkg;

  // tracker state, also read back through STAT[1:0]
  typedef enum logic [1:0] {
    st_off,     // disabled, motors stopped
    st_track,   // object in the last frame
    st_search,  // object missing, steer to last position
    st_lost     // miss limit reached, motors stopped
  } trk_state_e;

  // one camera report, 12 bits
  typedef struct packed {
    logic       valid;      // one-cycle strobe per frame
    logic [7:0] centroid;   // position pattern, zero when nothing seen
    logic [2:0] proximity;  // 0 far .. 5 near, 6/7 too close
  } frame_t;

  // wheel speeds in deg/s
  typedef struct packed {
    logic signed [`TRK_DPS_W-1:0] left;
    logic signed [`TRK_DPS_W-1:0] right;
  } motor_cmd_t;

  // software controls from the register block
  typedef struct packed {
    logic                  enable;
    logic [`TRK_CNT_W-1:0] limit;  // empty frames allowed before lost
  } trk_cfg_t;

endpackage

// File: hdl/track_regs.sv
// apb register block
// CTRL and LIMIT registers, STAT and MOTOR read-back
// zero wait states, pslverr on unmapped offsets
`timescale 1ns/1ps
`include "track_consts.svh"

module track_regs import track_pkg::*; (
  input  logic                  rst,      // clock
  input  logic                  clk,      // async reset, active high
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [3:0]            paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  output trk_cfg_t              cfg,
  input  trk_state_e            state,
  input  logic [`TRK_CNT_W-1:0] miss_cnt,
  input  motor_cmd_t            motor
);

  logic wr_en;   // access phase of a write
  logic mapped;  // paddr hits a register

  assign wr_en  = psel && penable && pwrite;
  assign pready = 1'b1;  // never stalls

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      cfg.enable <= 1'b0;
      cfg.limit  <= `TRK_CNT_W'(`TRK_LIMIT_RST);
    end else if (wr_en) begin
      case (paddr)
        `TRK_REG_CTRL:  cfg.enable <= pwdata[0];
        `TRK_REG_LIMIT: cfg.limit  <= pwdata[`TRK_CNT_W-1:0];
        default: ;  // STAT, MOTOR are read only, rest unmapped
      endcase
    end
  end

  // read mux, combinational on paddr
  always_comb begin
    prdata = '0;
    mapped = 1'b1;
    case (paddr)
      `TRK_REG_CTRL:  prdata[0] = cfg.enable;
      `TRK_REG_LIMIT: prdata[`TRK_CNT_W-1:0] = cfg.limit;
      `TRK_REG_STAT: begin
        prdata[1:0]            = state;
        prdata[8 +: `TRK_CNT_W] = miss_cnt;  // bits 13:8
      end
      `TRK_REG_MOTOR: prdata = {motor.right, motor.left};  // left in low half
      default:        mapped = 1'b0;
    endcase
  end

  // error only in the access phase
  assign pslverr = psel && penable && !mapped;

endmodule

// File: hdl/miss_timer.sv
// miss timer
// counts consecutive empty frames, saturates at the programmed limit
`timescale 1ns/1ps
`include "track_consts.svh"

module miss_timer import track_pkg::*; (
  input  logic                  rst,  // clock
  input  logic                  clk,  // async reset, active high
  input  trk_cfg_t              cfg,
  input  frame_t                frame,
  output logic [`TRK_CNT_W-1:0] miss_cnt,
  output logic                  expired
);

  // also true at once when limit is lowered under the count
  assign expired = (miss_cnt >= cfg.limit);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      miss_cnt <= '0;
    end else if (!cfg.enable) begin
      miss_cnt <= '0;  // disabled, start fresh
    end else if (frame.valid) begin
      if (|frame.centroid)
        miss_cnt <= '0;  // object seen
      else if (!expired)
        miss_cnt <= miss_cnt + 1'b1;
      // else hold, saturated
    end
  end

endmodule

// File: hdl/track_fsm.sv
// tracker state machine
// off, track, search and lost, stepped once per registered frame
`timescale 1ns/1ps

module track_fsm import track_pkg::*; (
  input  logic       rst,  // clock
  input  logic       clk,  // async reset, active high
  input  trk_cfg_t   cfg,
  input  frame_t     frame,
  input  logic       expired,
  output trk_state_e state
);

  logic       frm_q;  // frame strobe one cycle late
  logic       obj_q;  // that frame held an object
  logic       en_q;   // enable delayed, for edge detect
  trk_state_e state_nxt;

  // align with the timer, which updates on the frame edge itself
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      frm_q <= 1'b0;
      obj_q <= 1'b0;
      en_q  <= 1'b0;
    end else begin
      frm_q <= frame.valid;
      obj_q <= frame.valid && (|frame.centroid);
      en_q  <= cfg.enable;
    end
  end

  always_comb begin
    state_nxt = state;  // hold between frames
    if (!cfg.enable) begin
      state_nxt = st_off;
    end else if (state == st_off && !en_q) begin
      state_nxt = st_search;  // just enabled, steer to stored frame
    end else if (frm_q) begin
      if (obj_q)
        state_nxt = st_track;
      else if (expired)
        state_nxt = st_lost;
      else
        state_nxt = st_search;
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk)
      state <= st_off;
    else
      state <= state_nxt;
  end

endmodule

// File: hdl/steer_calc.sv
// steering calculation
// holds the last object frame, looks up base speed and side offset
// registers both wheel speeds, zero outside track and search
`timescale 1ns/1ps
`include "track_consts.svh"

module steer_calc import track_pkg::*; (
  input  logic       rst,  // clock
  input  logic       clk,  // async reset, active high
  input  frame_t     frame,
  input  trk_state_e state,
  output motor_cmd_t motor
);

  logic [7:0]                   cent_q;  // last nonzero centroid
  logic [2:0]                   prox_q;  // its proximity
  logic signed [`TRK_DPS_W-1:0] vel;     // base speed
  logic signed [`TRK_DPS_W-1:0] ofs;     // slow-side reduction
  logic signed [`TRK_DPS_W-1:0] slow;
  logic                         rev;     // backing away
  logic                         run;

  // last known position, empty frames leave it alone
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      cent_q <= '0;
      prox_q <= '0;
    end else if (frame.valid && (|frame.centroid)) begin
      cent_q <= frame.centroid;
      prox_q <= frame.proximity;
    end
  end

  // proximity to speed, far is fast
  always_comb begin
    case (prox_q)
      3'd0:    vel = `TRK_DPS_W'(`TRK_VEL5);
      3'd1:    vel = `TRK_DPS_W'(`TRK_VEL4);
      3'd2:    vel = `TRK_DPS_W'(`TRK_VEL3);
      3'd3:    vel = `TRK_DPS_W'(`TRK_VEL2);
      3'd4:    vel = `TRK_DPS_W'(`TRK_VEL1);
      3'd5:    vel = `TRK_DPS_W'(`TRK_VEL0);
      3'd6:    vel = `TRK_DPS_W'(-`TRK_VEL0);  // too close, back off
      default: vel = `TRK_DPS_W'(-`TRK_VEL1);
    endcase
  end

  assign rev = (prox_q[2:1] == 2'b11);  // codes 6 and 7

  // distance from centre, mirrored on both halves
  always_comb begin
    case (cent_q)
      8'h80, 8'h01: ofs = `TRK_DPS_W'(`TRK_OFS4);  // image edge
      8'h40, 8'h02: ofs = `TRK_DPS_W'(`TRK_OFS3);
      8'h20, 8'h04: ofs = `TRK_DPS_W'(`TRK_OFS2);
      8'h10, 8'h08: ofs = `TRK_DPS_W'(`TRK_OFS1);
      default:      ofs = '0;  // wide or odd pattern
    endcase
  end

  // in reverse the slow wheel moves toward zero from below
  assign slow = rev ? (vel + ofs) : (vel - ofs);
  assign run  = (state == st_track) || (state == st_search);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      motor <= '0;
    end else if (!run) begin
      motor <= '0;  // off or lost
    end else if (cent_q[4:3] == 2'b11) begin
      motor.left  <= vel;  // centred
      motor.right <= vel;
    end else if (|cent_q[3:0]) begin
      motor.left  <= rev ? vel : slow;  // target on the left half
      motor.right <= rev ? slow : vel;
    end else if (|cent_q[7:4]) begin
      motor.left  <= rev ? slow : vel;  // right half
      motor.right <= rev ? vel : slow;
    end else begin
      motor <= '0;  // nothing stored yet
    end
  end

endmodule

// File: hdl/track_top.sv
// steering controller top
// apb registers, miss timer, tracker fsm and steering
`timescale 1ns/1ps
`include "track_consts.svh"

module track_top import track_pkg::*; (
  input  logic        rst,  // clock
  input  logic        clk,  // async reset, active high
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  frame_t      frame,  // one report per valid strobe
  output motor_cmd_t  motor
);

  trk_cfg_t              cfg;
  trk_state_e            state;
  logic [`TRK_CNT_W-1:0] miss_cnt;
  logic                  expired;

  track_regs u_regs (
    .rst      (rst),
    .clk      (clk),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .cfg      (cfg),
    .state    (state),
    .miss_cnt (miss_cnt),
    .motor    (motor)  // read-back
  );

  miss_timer u_timer (
    .rst      (rst),
    .clk      (clk),
    .cfg      (cfg),
    .frame    (frame),
    .miss_cnt (miss_cnt),
    .expired  (expired)
  );

  track_fsm u_fsm (
    .rst     (rst),
    .clk     (clk),
    .cfg     (cfg),
    .frame   (frame),
    .expired (expired),
    .state   (state)
  );

  steer_calc u_steer (
    .rst   (rst),
    .clk   (clk),
    .frame (frame),
    .state (state),
    .motor (motor)
  );

endmodule

// File: bench/track_asserts.sv
// concurrent checks on tracker state, motor outputs and apb response
// bound into track_regs, which sees the state and motor read-back nets
`timescale 1ns/1ps

module track_asserts import track_pkg::*; (
  input logic       rst,  // clock
  input logic       clk,  // async reset, active high
  input trk_state_e state,
  input motor_cmd_t motor,
  input logic       psel,
  input logic       penable,
  input logic       pready,
  input logic       pslverr
);

  // motor register follows the state one edge later
  a_motor_idle: assert property (@(posedge rst) disable iff (clk)
    !(state inside {st_track, st_search}) |=> (motor == '0))
    else $error("motor nonzero after off or lost state");

  a_pready: assert property (@(posedge rst) disable iff (clk) pready)
    else $error("pready low");

  // error only in the access phase
  a_slverr: assert property (@(posedge rst) disable iff (clk)
    pslverr |-> (psel && penable))
    else $error("pslverr outside access phase");

endmodule

bind track_regs track_asserts u_asserts (
  .rst     (rst),
  .clk     (clk),
  .state   (state),
  .motor   (motor),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr)
);

// File: bench/track_tb.sv
// testbench for the steering controller
// apb and frame driver tasks, steering reference model
// directed tests for reset values, speed table, side offsets, miss limit, enable
`timescale 1ns/1ps
`include "track_consts.svh"

module track_tb import track_pkg::*; ();

  localparam int clk_ns      = 4;
  localparam int test_cycles = 20 + 60 + 100 + 50 + 30;  // rough sum of test lengths
  localparam int wd_ns       = (test_cycles + 100) * clk_ns;

  logic        rst;  // clock
  logic        clk;  // reset
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  frame_t      frame;
  motor_cmd_t  motor;

  integer      seed = 31;
  int          n_pass;
  int          n_fail;
  logic [31:0] rdata;
  logic        rerr;

  track_top dut (
    .rst     (rst),
    .clk     (clk),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .frame   (frame),
    .motor   (motor)
  );

  initial begin
    rst = 1'b0;
    forever #(clk_ns / 2) rst = ~rst;
  end

  // stop a hung run
  initial begin
    #(wd_ns);
    $display("timeout: tests did not finish within %0d ns", wd_ns);
    $display("Simulation failed");
    $finish;
  end

  task automatic check_val(input string name, input logic signed [31:0] exp,
                           input logic signed [31:0] act);
    if (exp !== act) begin
      n_fail++;
      $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end else begin
      n_pass++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge rst);
    #1;  // back to the drive point
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    psel    = 1'b1;  // setup phase
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge rst);
    #1 penable = 1'b1;
    @(posedge rst);  // write taken here
    #1 psel = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge rst);
    #1 penable = 1'b1;
    #1 data = prdata;  // combinational, settled mid cycle
    err = pslverr;
    check_val("pready", 1, pready);  // zero wait states
    @(posedge rst);
    #1 psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] cent, input logic [2:0] prox);
    frame.valid     = 1'b1;
    frame.centroid  = cent;
    frame.proximity = prox;
    @(posedge rst);  // sampling edge
    #1 frame = '0;
  endtask

  // expected wheel speeds for a stored frame while tracking or searching
  task automatic steer_model(input logic [7:0] cent, input logic [2:0] prox,
                             output int l, output int r);
    int   v;
    int   o;
    int   s;
    logic rev;
    case (prox)
      3'd0: v = `TRK_VEL5;
      3'd1: v = `TRK_VEL4;
      3'd2: v = `TRK_VEL3;
      3'd3: v = `TRK_VEL2;
      3'd4: v = `TRK_VEL1;
      3'd5: v = `TRK_VEL0;
      3'd6: v = -`TRK_VEL0;
      default: v = -`TRK_VEL1;
    endcase
    rev = (prox >= 3'd6);
    if (cent == 8'h80 || cent == 8'h01) o = `TRK_OFS4;
    else if (cent == 8'h40 || cent == 8'h02) o = `TRK_OFS3;
    else if (cent == 8'h20 || cent == 8'h04) o = `TRK_OFS2;
    else if (cent == 8'h10 || cent == 8'h08) o = `TRK_OFS1;
    else o = 0;
    s = rev ? v + o : v - o;
    if (cent[4] && cent[3]) begin
      l = v;
      r = v;
    end else if (cent[3:0] != 0) begin
      l = rev ? v : s;  // left half slows the left wheel going forward
      r = rev ? s : v;
    end else if (cent[7:4] != 0) begin
      l = rev ? s : v;
      r = rev ? v : s;
    end else begin
      l = 0;
      r = 0;
    end
  endtask

  task automatic check_motor(input logic [7:0] cent, input logic [2:0] prox);
    int l;
    int r;
    steer_model(cent, prox, l, r);
    check_val("motor.left", l, $signed(motor.left));
    check_val("motor.right", r, $signed(motor.right));
    apb_read(`TRK_REG_MOTOR, rdata, rerr);  // same speeds through read-back
    check_val("motor_reg.left", l, $signed(rdata[15:0]));
    check_val("motor_reg.right", r, $signed(rdata[31:16]));
  endtask

  task automatic check_stat(input trk_state_e st, input int cnt);
    apb_read(`TRK_REG_STAT, rdata, rerr);
    check_val("stat.state", st, rdata[1:0]);
    check_val("stat.miss_cnt", cnt, rdata[13:8]);
  endtask

  task automatic test_reset_values();
    int f0 = n_fail;
    apb_read(`TRK_REG_CTRL, rdata, rerr);
    check_val("ctrl", 0, rdata);
    check_val("pslverr", 0, rerr);
    apb_read(`TRK_REG_LIMIT, rdata, rerr);
    check_val("limit", `TRK_LIMIT_RST, rdata);
    apb_read(`TRK_REG_MOTOR, rdata, rerr);
    check_val("motor word", 0, rdata);
    check_stat(st_off, 0);
    apb_read(4'h6, rdata, rerr);  // hole in the 4-bit map
    check_val("pslverr", 1, rerr);
    $display("test reset_values done, %0d errors", n_fail - f0);
  endtask

  task automatic test_centred();
    int f0 = n_fail;
    apb_write(`TRK_REG_CTRL, 32'h1);
    for (int p = 0; p < 8; p++) begin
      send_frame(8'h18, p[2:0]);
      wait_cycles(3);
      check_motor(8'h18, p[2:0]);
    end
    $display("test centred done, %0d errors", n_fail - f0);
  endtask

  task automatic test_single_bits();
    int         f0 = n_fail;
    logic [2:0] prox;
    for (int dir = 0; dir < 2; dir++) begin
      for (int i = 0; i < 8; i++) begin
        if (dir == 0)
          prox = $unsigned($random(seed)) % 6;        // forward codes
        else
          prox = 3'd6 + $unsigned($random(seed)) % 2;  // reverse codes
        send_frame(8'h01 << i, prox);
        wait_cycles(3);
        check_motor(8'h01 << i, prox);
      end
    end
    $display("test single_bits done, %0d errors", n_fail - f0);
  endtask

  task automatic test_miss_limit();
    int f0 = n_fail;
    apb_write(`TRK_REG_LIMIT, 32'd3);
    send_frame(8'h04, 3'd2);
    wait_cycles(3);
    check_motor(8'h04, 3'd2);
    check_stat(st_track, 0);
    for (int k = 1; k <= 2; k++) begin
      send_frame(8'h00, 3'd0);
      wait_cycles(3);
      check_motor(8'h04, 3'd2);  // still steering to last position
      check_stat(st_search, k);
    end
    send_frame(8'h00, 3'd0);
    wait_cycles(3);
    check_val("motor.left", 0, $signed(motor.left));
    check_val("motor.right", 0, $signed(motor.right));
    check_stat(st_lost, 3);
    send_frame(8'h40, 3'd1);
    wait_cycles(3);
    check_motor(8'h40, 3'd1);
    check_stat(st_track, 0);
    $display("test miss_limit done, %0d errors", n_fail - f0);
  endtask

  task automatic test_enable_toggle();
    int f0 = n_fail;
    send_frame(8'h00, 3'd0);  // one miss, count leaves zero
    wait_cycles(3);
    check_stat(st_search, 1);
    apb_write(`TRK_REG_CTRL, 32'h0);
    wait_cycles(3);
    check_val("motor.left", 0, $signed(motor.left));
    check_val("motor.right", 0, $signed(motor.right));
    check_stat(st_off, 0);  // disable clears the count
    apb_write(`TRK_REG_CTRL, 32'h1);
    wait_cycles(3);
    check_stat(st_search, 0);
    check_motor(8'h40, 3'd1);  // stored frame from the last test
    $display("test enable_toggle done, %0d errors", n_fail - f0);
  endtask

  initial begin
    n_pass  = 0;
    n_fail  = 0;
    clk     = 1'b1;  // reset held from time zero
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    frame   = '0;
    repeat (4) @(posedge rst);
    #1 clk = 1'b0;
    test_reset_values();
    test_centred();
    test_single_bits();
    test_miss_limit();
    test_enable_toggle();
    $display("checks passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: list.f
+incdir+hdl
hdl/track_pkg.sv
hdl/track_regs.sv
hdl/miss_timer.sv
hdl/track_fsm.sv
hdl/steer_calc.sv
hdl/track_top.sv
bench/track_asserts.sv
bench/track_tb.sv

// File: Bender.yml
package:
  name: track_steer

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/track_pkg.sv
      - hdl/track_regs.sv
      - hdl/miss_timer.sv
      - hdl/track_fsm.sv
      - hdl/steer_calc.sv
      - hdl/track_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/track_asserts.sv
      - bench/track_tb.sv
